//--- bench/pq_props.sv
`timescale 1ns/1ns
`default_nettype none
`include "pq_cfg.svh"

module pq_props (
   input logic                  clk,
   input logic                  arst_n,
   input logic                  bvalid,
   input logic                  bready,
   input logic [1:0]            bresp,
   input logic                  rvalid,
   input logic                  rready,
   input logic [`PQ_DATA_W-1:0] rdata,
   input logic [1:0]            rresp,
   input logic                  busy,
   input logic [`PQ_IDX_W-1:0]  count,
   input logic                  enq_start,
   input logic                  deq_start
);

   ////////////////////
   // Handshakes
   ////////////////////

   // Write response held until bready
   assert property (@(posedge clk) disable iff (!arst_n)
      bvalid && !bready |=> bvalid && $stable(bresp))
      else $error("write response dropped or changed before bready");

   // Read data held until rready
   assert property (@(posedge clk) disable iff (!arst_n)
      rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
      else $error("read data dropped or changed before rready");

   ////////////////////
   // Sequencer
   ////////////////////

   assert property (@(posedge clk) disable iff (!arst_n) int'(count) <= `PQ_DEPTH)
      else $error("element count above queue depth");

   // Launches only meet an idle sequencer
   assert property (@(posedge clk) disable iff (!arst_n) $rose(enq_start) |-> !busy)
      else $error("enqueue launched while busy");

   assert property (@(posedge clk) disable iff (!arst_n) $rose(deq_start) |-> !busy)
      else $error("dequeue launched while busy");

endmodule

bind pq_axil_regs pq_props i_props (
   .clk(clk), .arst_n(arst_n),
   .bvalid(bvalid), .bready(bready), .bresp(bresp),
   .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
   .busy(busy), .count(count), .enq_start(enq_start), .deq_start(deq_start)
);

`default_nettype wire

//--- bench/pq_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "pq_cfg.svh"

module pq_tb;

   localparam int CLK_HALF   = 50;
   localparam int DRV_DLY    = 5;
   // Cycles allowed for a single handshake
   localparam int HS_TIMEOUT = 20;
   // STATUS reads allowed while the sequencer runs
   localparam int IDLE_POLLS = 50;
   localparam int MAX_OPS    = 96;

   localparam logic [31:0] OP_ENQ    = 32'h1;
   localparam logic [31:0] OP_DEQ    = 32'h2;
   localparam logic [31:0] OP_STATUS = 32'h3;
   localparam logic [31:0] OP_WRITE  = 32'h4;
   localparam logic [31:0] OP_READ   = 32'h5;
   localparam logic [31:0] OP_END    = 32'hf;

   localparam logic [1:0] RESP_OKAY = 2'b00;

   logic                  clk;
   logic                  arst_n;
   logic [`PQ_ADDR_W-1:0] awaddr;
   logic                  awvalid;
   logic                  awready;
   logic [`PQ_DATA_W-1:0] wdata;
   logic                  wvalid;
   logic                  wready;
   logic                  bvalid;
   logic [1:0]            bresp;
   logic                  bready;
   logic [`PQ_ADDR_W-1:0] araddr;
   logic                  arvalid;
   logic                  arready;
   logic                  rvalid;
   logic [`PQ_DATA_W-1:0] rdata;
   logic [1:0]            rresp;
   logic                  rready;

   // Four words per operation in the order op addr data expected
   logic [31:0] tests [MAX_OPS*4];
   // Stall generator state
   logic [31:0] rng_state;

   pq_top i_dut (
      .clk(clk), .arst_n(arst_n),
      .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
      .wdata(wdata), .wvalid(wvalid), .wready(wready),
      .bvalid(bvalid), .bresp(bresp), .bready(bready),
      .araddr(araddr), .arvalid(arvalid), .arready(arready),
      .rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready)
   );

   initial clk = 1'b0;
   always #(CLK_HALF) clk = ~clk;

   ////////////////////
   // Helpers
   ////////////////////

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // 0 to 3 cycles of ready held low
   function automatic int stall_cycles();
      rng_state = xorshift32(rng_state);
      return int'(rng_state[1:0]);
   endfunction

   // Next rising edge plus drive delay
   task automatic advance_cycle();
      @(posedge clk);
      #(DRV_DLY);
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout while waiting for %s at %0t", what, $time);
      $display("Simulation failed");
      $fatal(1, "wait timed out");
   endtask

   task automatic check_key(input string name, input logic [`PQ_DATA_W-1:0] got,
                            input logic [`PQ_DATA_W-1:0] expected);
      if (got !== expected) begin
         $display("[ERROR] time=%0t signal=%s got=%h expected=%h",
                  $time, name, got, expected);
         $display("Simulation failed");
         $fatal(1, "key mismatch");
      end
   endtask

   task automatic check_status(input string name, input logic [`PQ_DATA_W-1:0] got,
                               input logic [`PQ_DATA_W-1:0] expected);
      if (got !== expected) begin
         $display("[ERROR] time=%0t signal=%s got=%h expected=%h",
                  $time, name, got, expected);
         $display("Simulation failed");
         $fatal(1, "status mismatch");
      end
   endtask

   task automatic check_resp(input string name, input logic [1:0] got,
                             input logic [1:0] expected);
      if (got !== expected) begin
         $display("[ERROR] time=%0t signal=%s got=%b expected=%b",
                  $time, name, got, expected);
         $display("Simulation failed");
         $fatal(1, "response mismatch");
      end
   endtask

   ////////////////////
   // AXI4-Lite master
   ////////////////////

   task automatic write_reg(input logic [`PQ_ADDR_W-1:0] addr,
                            input logic [`PQ_DATA_W-1:0] data, output logic [1:0] resp);
      int waited;
      int stall;
      awaddr  = addr;
      wdata   = data;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      waited  = 0;
      // Both readies seen together, next edge completes the handshake
      while (!(awready && wready)) begin
         advance_cycle();
         waited++;
         if (waited > HS_TIMEOUT) report_timeout("awready and wready");
      end
      advance_cycle();
      awvalid = 1'b0;
      wvalid  = 1'b0;
      waited  = 0;
      while (!bvalid) begin
         advance_cycle();
         waited++;
         if (waited > HS_TIMEOUT) report_timeout("bvalid");
      end
      resp  = bresp;
      // Random back-pressure on the response
      stall = stall_cycles();
      repeat (stall) advance_cycle();
      bready = 1'b1;
      advance_cycle();
      bready = 1'b0;
   endtask

   task automatic read_reg(input logic [`PQ_ADDR_W-1:0] addr,
                           output logic [`PQ_DATA_W-1:0] data, output logic [1:0] resp);
      int waited;
      int stall;
      araddr  = addr;
      arvalid = 1'b1;
      waited  = 0;
      while (!arready) begin
         advance_cycle();
         waited++;
         if (waited > HS_TIMEOUT) report_timeout("arready");
      end
      advance_cycle();
      arvalid = 1'b0;
      waited  = 0;
      while (!rvalid) begin
         advance_cycle();
         waited++;
         if (waited > HS_TIMEOUT) report_timeout("rvalid");
      end
      data  = rdata;
      resp  = rresp;
      stall = stall_cycles();
      repeat (stall) advance_cycle();
      rready = 1'b1;
      advance_cycle();
      rready = 1'b0;
   endtask

   // Poll STATUS until the busy bit drops
   task automatic wait_idle(output logic [`PQ_DATA_W-1:0] status);
      int         polls;
      logic [1:0] resp;
      polls = 0;
      read_reg(`PQ_ADDR_STATUS, status, resp);
      check_resp("rresp", resp, RESP_OKAY);
      while (status[10]) begin
         polls++;
         if (polls > IDLE_POLLS) report_timeout("busy to fall");
         read_reg(`PQ_ADDR_STATUS, status, resp);
         check_resp("rresp", resp, RESP_OKAY);
      end
   endtask

   ////////////////////
   // Stimulus
   ////////////////////

   initial begin
      int                    op_idx;
      logic                  done;
      logic [31:0]           op;
      logic [31:0]           addr;
      logic [31:0]           data;
      logic [31:0]           expected;
      logic [1:0]            resp;
      logic [`PQ_DATA_W-1:0] rd;

      arst_n    = 1'b0;
      awaddr    = '0;
      awvalid   = 1'b0;
      wdata     = '0;
      wvalid    = 1'b0;
      bready    = 1'b0;
      araddr    = '0;
      arvalid   = 1'b0;
      rready    = 1'b0;
      rng_state = 32'h482f5700;
      $readmemh("bench/pq_tests.txt", tests);

      repeat (10) @(posedge clk);
      #(DRV_DLY);
      arst_n = 1'b1;
      advance_cycle();

      op_idx = 0;
      done   = 1'b0;
      while (!done) begin
         op       = tests[op_idx*4];
         addr     = tests[op_idx*4+1];
         data     = tests[op_idx*4+2];
         expected = tests[op_idx*4+3];
         case (op)
            OP_ENQ: begin
               write_reg(`PQ_ADDR_ENQ, data, resp);
               check_resp("bresp", resp, RESP_OKAY);
               wait_idle(rd);
            end
            // Launch and wait for the shift to finish before fetching the key
            OP_DEQ: begin
               write_reg(`PQ_ADDR_DEQ, '0, resp);
               check_resp("bresp", resp, RESP_OKAY);
               wait_idle(rd);
               read_reg(`PQ_ADDR_RESULT, rd, resp);
               check_resp("rresp", resp, RESP_OKAY);
               check_key("RESULT", rd, expected);
            end
            OP_STATUS: begin
               wait_idle(rd);
               check_status("STATUS", rd, expected);
            end
            // Raw accesses without waiting for the sequencer
            OP_WRITE: begin
               write_reg(addr[`PQ_ADDR_W-1:0], data, resp);
               check_resp("bresp", resp, expected[1:0]);
            end
            OP_READ: begin
               read_reg(addr[`PQ_ADDR_W-1:0], rd, resp);
               check_resp("rresp", resp, expected[1:0]);
            end
            OP_END: begin
               done = 1'b1;
            end
            default: begin
               $display("Unknown operation %h on test line %0d", op, op_idx);
               $display("Simulation failed");
               $fatal(1, "bad test file");
            end
         endcase
         op_idx++;
         if (!done && op_idx >= MAX_OPS) begin
            $display("Test file has no end marker within %0d operations", MAX_OPS);
            $display("Simulation failed");
            $fatal(1, "bad test file");
         end
      end

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

//--- bench/pq_tests.txt
// Columns: op addr data expected, hex. op 1 enq data, 2 deq expected key, 3 status word,
// 4 write addr data expected bresp, 5 read addr expected rresp, f end
// Reset state, empty queue
00000003 00000000 00000000 00000100
// Mapped read is OKAY, unmapped write and read are SLVERR
00000005 00000008 00000000 00000000
00000004 00000010 00000000 00000002
00000005 000000fc 00000000 00000002
// Dequeue from empty sets underflow, write one clears it
00000004 00000004 00000000 00000000
00000003 00000000 00000000 00020100
00000004 0000000c 00020000 00000000
00000003 00000000 00000000 00000100
// Sixteen keys in mixed order
00000001 00000000 00000042 00000000
00000001 00000000 80000000 00000000
00000001 00000000 00000001 00000000
00000001 00000000 ffffffff 00000000
00000001 00000000 00001000 00000000
00000001 00000000 7fffffff 00000000
00000001 00000000 00000000 00000000
00000001 00000000 000000ff 00000000
00000003 00000000 00000000 00000008
00000001 00000000 12345678 00000000
00000001 00000000 00000100 00000000
00000001 00000000 c0000000 00000000
00000001 00000000 00000010 00000000
00000001 00000000 00abcdef 00000000
00000001 00000000 40000000 00000000
00000001 00000000 00000002 00000000
00000001 00000000 00000080 00000000
// Full with count 16
00000003 00000000 00000000 00000210
// Enqueue while full sets overflow, count stays
00000001 00000000 55555555 00000000
00000003 00000000 00000000 00010210
00000004 0000000c 00010000 00000000
00000003 00000000 00000000 00000210
// Second dequeue hits the running one and sets collision
00000004 00000004 00000000 00000000
00000004 00000004 00000000 00000000
00000003 00000000 00000000 0004000f
00000004 0000000c 00040000 00000000
00000003 00000000 00000000 0000000f
// Remaining keys come out in descending order
00000002 00000000 00000000 c0000000
00000002 00000000 00000000 80000000
00000002 00000000 00000000 7fffffff
00000002 00000000 00000000 40000000
00000002 00000000 00000000 12345678
00000002 00000000 00000000 00abcdef
00000002 00000000 00000000 00001000
00000002 00000000 00000000 00000100
00000003 00000000 00000000 00000007
00000002 00000000 00000000 000000ff
00000002 00000000 00000000 00000080
00000002 00000000 00000000 00000042
00000002 00000000 00000000 00000010
00000002 00000000 00000000 00000002
00000002 00000000 00000000 00000001
00000002 00000000 00000000 00000000
00000003 00000000 00000000 00000100
0000000f 00000000 00000000 00000000

//--- design/pq_array_ram.sv
`timescale 1ns/1ns
`default_nettype none
`include "pq_cfg.svh"

module pq_array_ram #(
   parameter int ADDR_W = $clog2(`PQ_DEPTH)
) (
   input  logic                  clk,
   input  logic                  rd_en,
   input  logic [ADDR_W-1:0]     rd_addr,
   input  logic                  wr_en,
   input  logic [ADDR_W-1:0]     wr_addr,
   input  logic [`PQ_DATA_W-1:0] wr_data,
   output logic [`PQ_DATA_W-1:0] rd_data
);

   // Key storage, slot 0 holds the maximum
   logic [`PQ_DATA_W-1:0] mem [`PQ_DEPTH];

   // Write port
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // Registered read, data valid the cycle after rd_en
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_data <= mem[rd_addr];
      end
   end

endmodule

`default_nettype wire

//--- design/pq_axil_regs.sv
`timescale 1ns/1ns
`default_nettype none
`include "pq_cfg.svh"

module pq_axil_regs (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic [`PQ_ADDR_W-1:0] awaddr,
   input  logic                  awvalid,
   output logic                  awready,
   input  logic [`PQ_DATA_W-1:0] wdata,
   input  logic                  wvalid,
   output logic                  wready,
   output logic                  bvalid,
   output logic [1:0]            bresp,
   input  logic                  bready,
   input  logic [`PQ_ADDR_W-1:0] araddr,
   input  logic                  arvalid,
   output logic                  arready,
   output logic                  rvalid,
   output logic [`PQ_DATA_W-1:0] rdata,
   output logic [1:0]            rresp,
   input  logic                  rready,
   input  logic                  busy,
   input  logic [`PQ_IDX_W-1:0]  count,
   input  logic                  deq_done,
   input  logic [`PQ_DATA_W-1:0] deq_key,
   output logic                  enq_start,
   output logic [`PQ_DATA_W-1:0] enq_key,
   output logic                  deq_start
);

   localparam logic [1:0]           RESP_OKAY   = 2'b00;
   localparam logic [1:0]           RESP_SLVERR = 2'b10;
   localparam logic [`PQ_IDX_W-1:0] DEPTH_CNT   = `PQ_DEPTH;

   logic                  aw_rdy;
   logic                  wr_hs;
   logic                  ar_rdy;
   logic                  full;
   logic                  empty;
   // Sequencer running or about to start
   logic                  seq_active;
   logic                  overflow;
   logic                  underflow;
   logic                  collision;
   logic [`PQ_DATA_W-1:0] result;
   logic [`PQ_DATA_W-1:0] status_word;

   // Address and data accepted together
   assign awready    = aw_rdy;
   assign wready     = aw_rdy;
   assign wr_hs      = aw_rdy && awvalid && wvalid;
   assign arready    = ar_rdy;
   assign full       = (count == DEPTH_CNT);
   assign empty      = (count == '0);
   assign seq_active = busy || enq_start || deq_start;

   // Count, flags, then sticky errors in the upper half
   assign status_word = {13'd0, collision, underflow, overflow,
                         5'd0, busy, full, empty, 3'd0, count};

   ////////////////////
   // Write channel
   ////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         aw_rdy    <= 1'b0;
         bvalid    <= 1'b0;
         enq_start <= 1'b0;
         deq_start <= 1'b0;
         overflow  <= 1'b0;
         underflow <= 1'b0;
         collision <= 1'b0;
      end else begin
         enq_start <= 1'b0;
         deq_start <= 1'b0;
         // One-cycle ready pulse, held off while a response waits
         aw_rdy <= awvalid && wvalid && !bvalid && !aw_rdy;
         if (bvalid && bready) begin
            bvalid <= 1'b0;
         end
         if (wr_hs) begin
            bvalid <= 1'b1;
            case (awaddr)
               `PQ_ADDR_ENQ: begin
                  if (seq_active) collision <= 1'b1;
                  else if (full) overflow <= 1'b1;
                  else enq_start <= 1'b1;
               end
               `PQ_ADDR_DEQ: begin
                  if (seq_active) collision <= 1'b1;
                  else if (empty) underflow <= 1'b1;
                  else deq_start <= 1'b1;
               end
               // Write one to clear
               `PQ_ADDR_STATUS: begin
                  if (wdata[16]) overflow <= 1'b0;
                  if (wdata[17]) underflow <= 1'b0;
                  if (wdata[18]) collision <= 1'b0;
               end
               default: begin
               end
            endcase
         end
      end
   end

   // Response code and enqueue key
   always_ff @(posedge clk) begin
      if (wr_hs) begin
         enq_key <= wdata;
         bresp   <= (awaddr inside {`PQ_ADDR_ENQ, `PQ_ADDR_DEQ, `PQ_ADDR_RESULT,
                                    `PQ_ADDR_STATUS}) ? RESP_OKAY : RESP_SLVERR;
      end
   end

   ////////////////////
   // Read channel
   ////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ar_rdy <= 1'b0;
         rvalid <= 1'b0;
         result <= '0;
      end else begin
         ar_rdy <= arvalid && !rvalid && !ar_rdy;
         if (rvalid && rready) begin
            rvalid <= 1'b0;
         end
         if (ar_rdy && arvalid) begin
            rvalid <= 1'b1;
         end
         // Last dequeued key
         if (deq_done) begin
            result <= deq_key;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (ar_rdy && arvalid) begin
         rresp <= RESP_OKAY;
         case (araddr)
            `PQ_ADDR_RESULT: rdata <= result;
            `PQ_ADDR_STATUS: rdata <= status_word;
            // Command registers read as zero
            `PQ_ADDR_ENQ, `PQ_ADDR_DEQ: rdata <= '0;
            default: begin
               rdata <= '0;
               rresp <= RESP_SLVERR;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- design/pq_pkg.sv
`default_nettype none

package pq_pkg;

   ////////////////////
   // Router modes
   ////////////////////

   typedef enum logic [2:0] {
      // Stored key passes through
      mode_idle       = 3'd0,
      // Larger key stays, smaller one moves on
      mode_enq_cmp    = 3'd1,
      // Next slot moves up by one
      mode_deq_shift  = 3'd2,
      // Carry lands in the tail slot
      mode_tail_write = 3'd3
   } pq_mode_e;

   ////////////////////
   // Sequencer states
   ////////////////////

   typedef enum logic [2:0] {
      st_idle     = 3'd0,
      st_enq_read = 3'd1,
      st_enq_step = 3'd2,
      st_deq_read = 3'd3,
      st_deq_step = 3'd4
   } pq_state_e;

endpackage

`default_nettype wire

//--- design/pq_sequencer.sv
`timescale 1ns/1ns
`default_nettype none
`include "pq_cfg.svh"

module pq_sequencer
   import pq_pkg::*;
#(
   parameter int ADDR_W = $clog2(`PQ_DEPTH)
) (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  enq_start,
   input  logic [`PQ_DATA_W-1:0] enq_key,
   input  logic                  deq_start,
   input  logic [`PQ_DATA_W-1:0] rd_data,
   input  logic [`PQ_DATA_W-1:0] slot_data,
   input  logic [`PQ_DATA_W-1:0] carry_next,
   input  logic                  last_slot,
   output logic                  busy,
   output logic [`PQ_IDX_W-1:0]  count,
   output logic                  deq_done,
   output logic [`PQ_DATA_W-1:0] deq_key,
   output logic                  rd_en,
   output logic [ADDR_W-1:0]     rd_addr,
   output logic                  wr_en,
   output logic [ADDR_W-1:0]     wr_addr,
   output logic [`PQ_DATA_W-1:0] wr_data,
   output pq_mode_e              mode,
   output logic [`PQ_DATA_W-1:0] carry,
   output logic [`PQ_IDX_W-1:0]  index
);

   pq_state_e            state;
   // Slot above the current one, target of a shift
   logic [`PQ_IDX_W-1:0] index_prev;

   assign busy       = (state != st_idle);
   assign index_prev = index - 1'b1;
   assign rd_addr    = index[ADDR_W-1:0];
   assign wr_data    = slot_data;

   ////////////////////
   // Control state
   ////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= st_idle;
         index    <= '0;
         count    <= '0;
         deq_done <= 1'b0;
      end else begin
         deq_done <= 1'b0;
         case (state)
            st_idle: begin
               index <= '0;
               if (enq_start) begin
                  state <= st_enq_read;
               end else if (deq_start) begin
                  state <= st_deq_read;
               end
            end

            // Tail write ends the walk, otherwise fetch this slot
            st_enq_read: begin
               if (last_slot) begin
                  count <= count + 1'b1;
                  state <= st_idle;
               end else begin
                  state <= st_enq_step;
               end
            end

            // Compare-and-swap written back, move to next slot
            st_enq_step: begin
               index <= index + 1'b1;
               state <= st_enq_read;
            end

            st_deq_read: begin
               state <= st_deq_step;
            end

            st_deq_step: begin
               if (last_slot) begin
                  count    <= count - 1'b1;
                  deq_done <= 1'b1;
                  state    <= st_idle;
               end else begin
                  index <= index + 1'b1;
                  state <= st_deq_read;
               end
            end

            default: begin
               state <= st_idle;
            end
         endcase
      end
   end

   ////////////////////
   // Carry and result
   ////////////////////

   always_ff @(posedge clk) begin
      // New key enters the carry at launch
      if (state == st_idle && enq_start) begin
         carry <= enq_key;
      end else if (state == st_enq_step) begin
         carry <= carry_next;
      end
      // Slot 0 is the dequeued maximum
      if (state == st_deq_step && index == '0) begin
         deq_key <= rd_data;
      end
   end

   // Router mode and array strobes per state
   always_comb begin
      mode    = mode_idle;
      rd_en   = 1'b0;
      wr_en   = 1'b0;
      wr_addr = index[ADDR_W-1:0];
      case (state)
         st_enq_read: begin
            mode  = mode_tail_write;
            rd_en = !last_slot;
            wr_en = last_slot;
         end
         st_enq_step: begin
            mode  = mode_enq_cmp;
            wr_en = 1'b1;
         end
         st_deq_read: begin
            rd_en = 1'b1;
         end
         st_deq_step: begin
            mode    = mode_deq_shift;
            // Slot 0 is only read, later slots move up
            wr_en   = (index != '0);
            wr_addr = index_prev[ADDR_W-1:0];
         end
         default: begin
            mode = mode_idle;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- design/pq_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "pq_cfg.svh"

module pq_top
   import pq_pkg::*;
(
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic [`PQ_ADDR_W-1:0] awaddr,
   input  logic                  awvalid,
   output logic                  awready,
   input  logic [`PQ_DATA_W-1:0] wdata,
   input  logic                  wvalid,
   output logic                  wready,
   output logic                  bvalid,
   output logic [1:0]            bresp,
   input  logic                  bready,
   input  logic [`PQ_ADDR_W-1:0] araddr,
   input  logic                  arvalid,
   output logic                  arready,
   output logic                  rvalid,
   output logic [`PQ_DATA_W-1:0] rdata,
   output logic [1:0]            rresp,
   input  logic                  rready
);

   localparam int ADDR_W = $clog2(`PQ_DEPTH);

   // Command path
   logic                  enq_start;
   logic                  deq_start;
   logic [`PQ_DATA_W-1:0] enq_key;
   logic                  busy;
   logic [`PQ_IDX_W-1:0]  count;
   logic                  deq_done;
   logic [`PQ_DATA_W-1:0] deq_key;

   // Array ports
   logic                  rd_en;
   logic [ADDR_W-1:0]     rd_addr;
   logic [`PQ_DATA_W-1:0] rd_data;
   logic                  wr_en;
   logic [ADDR_W-1:0]     wr_addr;
   logic [`PQ_DATA_W-1:0] wr_data;

   // Router ports
   pq_mode_e              mode;
   logic [`PQ_DATA_W-1:0] carry;
   logic [`PQ_DATA_W-1:0] carry_next;
   logic [`PQ_DATA_W-1:0] slot_data;
   logic [`PQ_IDX_W-1:0]  index;
   logic                  last_slot;

   pq_axil_regs i_regs (
      .clk(clk), .arst_n(arst_n),
      .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
      .wdata(wdata), .wvalid(wvalid), .wready(wready),
      .bvalid(bvalid), .bresp(bresp), .bready(bready),
      .araddr(araddr), .arvalid(arvalid), .arready(arready),
      .rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready),
      .busy(busy), .count(count), .deq_done(deq_done), .deq_key(deq_key),
      .enq_start(enq_start), .enq_key(enq_key), .deq_start(deq_start)
   );

   pq_sequencer #(.ADDR_W(ADDR_W)) i_seq (
      .clk(clk), .arst_n(arst_n),
      .enq_start(enq_start), .enq_key(enq_key), .deq_start(deq_start),
      .rd_data(rd_data), .slot_data(slot_data), .carry_next(carry_next),
      .last_slot(last_slot), .busy(busy), .count(count),
      .deq_done(deq_done), .deq_key(deq_key),
      .rd_en(rd_en), .rd_addr(rd_addr),
      .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
      .mode(mode), .carry(carry), .index(index)
   );

   // Stored key comes straight from the array read port
   pq_value_router i_router (
      .mode(mode), .carry(carry), .stored(rd_data),
      .index(index), .count(count),
      .slot_data(slot_data), .carry_next(carry_next), .last_slot(last_slot)
   );

   pq_array_ram #(.ADDR_W(ADDR_W)) i_ram (
      .clk(clk),
      .rd_en(rd_en), .rd_addr(rd_addr),
      .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
      .rd_data(rd_data)
   );

endmodule

`default_nettype wire

//--- design/pq_value_router.sv
`timescale 1ns/1ns
`default_nettype none
`include "pq_cfg.svh"

module pq_value_router
   import pq_pkg::*;
(
   input  pq_mode_e              mode,
   input  logic [`PQ_DATA_W-1:0] carry,
   input  logic [`PQ_DATA_W-1:0] stored,
   input  logic [`PQ_IDX_W-1:0]  index,
   input  logic [`PQ_IDX_W-1:0]  count,
   output logic [`PQ_DATA_W-1:0] slot_data,
   output logic [`PQ_DATA_W-1:0] carry_next,
   output logic                  last_slot
);

   // Carry strictly larger than the slot key
   logic                 carry_wins;
   // Index of the last occupied slot
   logic [`PQ_IDX_W-1:0] count_m1;

   assign carry_wins = carry > stored;
   assign count_m1   = count - 1'b1;

   always_comb begin
      // Pass-through unless a mode says otherwise
      slot_data  = stored;
      carry_next = carry;
      last_slot  = 1'b0;

      case (mode)
         mode_enq_cmp: begin
            // Swap when the carry beats the slot
            if (carry_wins) begin
               slot_data  = carry;
               carry_next = stored;
            end
            last_slot = (index == count);
         end

         mode_deq_shift: begin
            // Key read from the next slot goes one slot up
            slot_data = stored;
            last_slot = (index == count_m1);
         end

         mode_tail_write: begin
            // Walk reached the end, carry fills the free slot
            slot_data = carry;
            last_slot = (index == count);
         end

         default: begin
            slot_data  = stored;
            carry_next = carry;
            last_slot  = 1'b0;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+include
design/pq_pkg.sv
design/pq_value_router.sv
design/pq_array_ram.sv
design/pq_sequencer.sv
design/pq_axil_regs.sv
design/pq_top.sv
bench/pq_props.sv
bench/pq_tb.sv

//--- include/pq_cfg.svh
`ifndef PQ_CFG_SVH
`define PQ_CFG_SVH

////////////////////
// Queue geometry
////////////////////

// Key and register width
`define PQ_DATA_W 32
// Number of array slots
`define PQ_DEPTH 16
// Slot index and count, one bit more than the slot address so a full count fits
`define PQ_IDX_W 5

////////////////////
// AXI4-Lite map
////////////////////

// Byte address width seen by the register block
`define PQ_ADDR_W 8
`define PQ_ADDR_ENQ    8'h00
`define PQ_ADDR_DEQ    8'h04
`define PQ_ADDR_RESULT 8'h08
`define PQ_ADDR_STATUS 8'h0C

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the priority queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module pq_tb -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/Vpq_tb 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulator exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qxF "Simulation completed successfully"; then
   exit 0
fi
echo "Pass message not found in simulator output"
exit 1
